// File: command_issue/command_arbiter.sv
`timescale 1ns/1ps

module command_arbiter import afu_pkg::*; (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         enabled,
	input  logic [NUM_SOURCES-1:0]       source_empty,
	input  cmd_code_t [NUM_SOURCES-1:0]  source_code,
	input  address_t [NUM_SOURCES-1:0]   source_address,
	input  logic                         credit_available,
	input  logic                         tag_ready,
	input  tag_t                         free_tag,
	output logic [NUM_SOURCES-1:0]       pop,
	output logic                         issue,
	output cmd_source_t                  issue_source,
	output logic                         command_valid,
	output cmd_code_t                    command_code,
	output address_t                     command_address,
	output tag_t                         command_tag
);

	logic can_issue;

	// Need a credit and a tag before anything goes out
	assign can_issue = enabled && credit_available && tag_ready;

	//////////////////////////////
	// Fixed priority grant
	//////////////////////////////

	always_comb begin
		pop          = '0;
		issue_source = SOURCE_RESTART;
		// Walk down so the lowest index wins
		for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
			if (!source_empty[i]) begin
				pop          = '0;
				pop[i]       = can_issue;
				issue_source = cmd_source_t'(i);
			end
		end
	end

	assign issue = |pop;

	//////////////////////////////
	// Registered command port
	//////////////////////////////

	// One pulse per grant
	always_ff @(posedge clock) begin
		if (!rst_n)
			command_valid <= 1'b0;
		else
			command_valid <= issue;
	end

	// Head of the granted queue plus the tag it was given
	always_ff @(posedge clock) begin
		if (issue) begin
			command_code    <= source_code[issue_source];
			command_address <= source_address[issue_source];
			command_tag     <= free_tag;
		end
	end

endmodule

// File: command_issue/credit_tracker.sv
`timescale 1ns/1ps

module credit_tracker import afu_pkg::*; (
	input  logic    clock,
	input  logic    rst_n,
	input  logic    enabled,
	input  credit_t room,
	input  logic    issue,
	input  logic    response_valid,
	input  credit_t response_credits,
	output logic    credit_available
);

	logic    enabled_d;
	logic    enable_rise;
	credit_t credit_count;
	credit_t credit_base;
	credit_t credit_return;
	credit_t credit_next;

	// Link comes up, room gives the starting count
	assign enable_rise = enabled && !enabled_d;

	//////////////////////////////
	// Next count
	//////////////////////////////

	always_comb begin
		credit_base   = enable_rise ? room : credit_count;
		credit_return = response_valid ? response_credits : '0;
		// Issue and return may land on the same edge
		credit_next   = credit_base + credit_return - credit_t'(issue);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			enabled_d    <= 1'b0;
			credit_count <= '0;
		end else begin
			enabled_d    <= enabled;
			credit_count <= credit_next;
		end
	end

	// Count left from before the link came up is stale until room is loaded
	assign credit_available = (credit_count != '0) && !enable_rise;

endmodule

// File: command_issue/tag_table.sv
`timescale 1ns/1ps

module tag_table import afu_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        issue,
	input  cmd_source_t issue_source,
	input  tag_t        issue_tag,
	input  logic        lookup_valid,
	input  tag_t        lookup_tag,
	output logic        tag_ready,
	output tag_t        free_tag,
	output cmd_source_t owner_source,
	output logic        owner_hit
);

	logic [TAG_COUNT-1:0] in_use;
	cmd_source_t          owner [TAG_COUNT];
	tag_index_t           free_index;
	tag_index_t           issue_index;
	tag_index_t           lookup_index;
	logic                 lookup_in_range;

	assign issue_index  = issue_tag[TAG_INDEX_WIDTH-1:0];
	assign lookup_index = lookup_tag[TAG_INDEX_WIDTH-1:0];

	// Tags above the table never match
	assign lookup_in_range = (lookup_tag < tag_t'(TAG_COUNT));

	//////////////////////////////
	// Free tag search
	//////////////////////////////

	// Lowest free entry
	always_comb begin
		free_index = '0;
		for (int i = TAG_COUNT - 1; i >= 0; i--) begin
			if (!in_use[i])
				free_index = tag_index_t'(i);
		end
	end

	assign tag_ready = !(&in_use);
	assign free_tag  = tag_t'(free_index);

	//////////////////////////////
	// Owner lookup
	//////////////////////////////

	assign owner_source = owner[lookup_index];
	assign owner_hit    = lookup_in_range && in_use[lookup_index];

	//////////////////////////////
	// Entry state
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			in_use <= '0;
		end else begin
			// Response releases its tag
			if (lookup_valid && lookup_in_range)
				in_use[lookup_index] <= 1'b0;
			// New command claims one, last so it wins on a clash
			if (issue)
				in_use[issue_index] <= 1'b1;
		end
	end

	// Owning source per tag
	always_ff @(posedge clock) begin
		if (issue)
			owner[issue_index] <= issue_source;
	end

endmodule

// File: common/afu_pkg.sv
package afu_pkg;

	//////////////////////////////
	// Link field widths
	//////////////////////////////

	// Command opcode as sent on the link
	typedef logic [12:0] cmd_code_t;

	// Effective address
	typedef logic [63:0] address_t;

	// Command tag on the link
	typedef logic [7:0] tag_t;

	// Credit count, also the credit return field
	typedef logic [7:0] credit_t;

	// Host response code
	typedef logic [7:0] resp_code_t;

	//////////////////////////////
	// Command sources
	//////////////////////////////

	// Lower value wins arbitration
	typedef enum logic [1:0] {
		SOURCE_RESTART = 2'd0,
		SOURCE_WRITE   = 2'd1,
		SOURCE_READ    = 2'd2
	} cmd_source_t;

	localparam int NUM_SOURCES = 3;

	//////////////////////////////
	// Tags and queues
	//////////////////////////////

	// Tags that may be outstanding at once
	localparam int TAG_COUNT = 16;
	localparam int TAG_INDEX_WIDTH = $clog2(TAG_COUNT);

	// Index into the tag table
	typedef logic [TAG_INDEX_WIDTH-1:0] tag_index_t;

	// Success code, anything else is an error
	localparam resp_code_t RESP_DONE = 8'h00;

	// Queue depths per source
	localparam int READ_QUEUE_DEPTH    = 16;
	localparam int WRITE_QUEUE_DEPTH   = 16;
	localparam int RESTART_QUEUE_DEPTH = 2;

	// Queue entry is code and address packed
	localparam int QUEUE_WIDTH = $bits(cmd_code_t) + $bits(address_t);

endpackage

// File: design/afu_command_top.sv
`timescale 1ns/1ps

module afu_command_top import afu_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       enabled,
	input  credit_t    room,
	// Restart source
	input  logic       restart_push,
	input  cmd_code_t  restart_code,
	input  address_t   restart_address,
	output logic       restart_full,
	// Write source
	input  logic       write_push,
	input  cmd_code_t  write_code,
	input  address_t   write_address,
	output logic       write_full,
	// Read source
	input  logic       read_push,
	input  cmd_code_t  read_code,
	input  address_t   read_address,
	output logic       read_full,
	// Link command port
	output logic       command_valid,
	output cmd_code_t  command_code,
	output address_t   command_address,
	output tag_t       command_tag,
	// Host response port
	input  logic       response_valid,
	input  tag_t       response_tag,
	input  resp_code_t response_code,
	input  credit_t    response_credits,
	// Routed responses
	output logic       restart_response_valid,
	output tag_t       restart_response_tag,
	output resp_code_t restart_response_code,
	output logic       restart_response_error,
	output logic       write_response_valid,
	output tag_t       write_response_tag,
	output resp_code_t write_response_code,
	output logic       write_response_error,
	output logic       read_response_valid,
	output tag_t       read_response_tag,
	output resp_code_t read_response_code,
	output logic       read_response_error,
	output logic       tag_error
);

	logic [QUEUE_WIDTH-1:0]       restart_head;
	logic [QUEUE_WIDTH-1:0]       write_head;
	logic [QUEUE_WIDTH-1:0]       read_head;
	logic [NUM_SOURCES-1:0]       queue_empty;
	logic [NUM_SOURCES-1:0]       queue_pop;
	cmd_code_t [NUM_SOURCES-1:0]  head_code;
	address_t [NUM_SOURCES-1:0]   head_address;
	logic                         credit_available;
	logic                         tag_ready;
	tag_t                         free_tag;
	logic                         issue;
	cmd_source_t                  issue_source;
	logic                         lookup_valid;
	tag_t                         lookup_tag;
	cmd_source_t                  owner_source;
	logic                         owner_hit;
	logic [NUM_SOURCES-1:0]       routed_valid;
	tag_t [NUM_SOURCES-1:0]       routed_tag;
	resp_code_t [NUM_SOURCES-1:0] routed_code;
	logic [NUM_SOURCES-1:0]       routed_error;

	//////////////////////////////
	// Command queues
	//////////////////////////////

	command_queue #(.DEPTH(RESTART_QUEUE_DEPTH), .WIDTH(QUEUE_WIDTH)) restart_queue (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (restart_push),
		.data_in  ({restart_code, restart_address}),
		.pop      (queue_pop[SOURCE_RESTART]),
		.data_out (restart_head),
		.empty    (queue_empty[SOURCE_RESTART]),
		.full     (restart_full)
	);

	command_queue #(.DEPTH(WRITE_QUEUE_DEPTH), .WIDTH(QUEUE_WIDTH)) write_queue (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (write_push),
		.data_in  ({write_code, write_address}),
		.pop      (queue_pop[SOURCE_WRITE]),
		.data_out (write_head),
		.empty    (queue_empty[SOURCE_WRITE]),
		.full     (write_full)
	);

	command_queue #(.DEPTH(READ_QUEUE_DEPTH), .WIDTH(QUEUE_WIDTH)) read_queue (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (read_push),
		.data_in  ({read_code, read_address}),
		.pop      (queue_pop[SOURCE_READ]),
		.data_out (read_head),
		.empty    (queue_empty[SOURCE_READ]),
		.full     (read_full)
	);

	// Unpack heads by source
	assign {head_code[SOURCE_RESTART], head_address[SOURCE_RESTART]} = restart_head;
	assign {head_code[SOURCE_WRITE], head_address[SOURCE_WRITE]}     = write_head;
	assign {head_code[SOURCE_READ], head_address[SOURCE_READ]}       = read_head;

	//////////////////////////////
	// Issue path
	//////////////////////////////

	command_arbiter arbiter (
		.clock            (clock),
		.rst_n            (rst_n),
		.enabled          (enabled),
		.source_empty     (queue_empty),
		.source_code      (head_code),
		.source_address   (head_address),
		.credit_available (credit_available),
		.tag_ready        (tag_ready),
		.free_tag         (free_tag),
		.pop              (queue_pop),
		.issue            (issue),
		.issue_source     (issue_source),
		.command_valid    (command_valid),
		.command_code     (command_code),
		.command_address  (command_address),
		.command_tag      (command_tag)
	);

	// Credits come back with the raw host response
	credit_tracker credits (
		.clock            (clock),
		.rst_n            (rst_n),
		.enabled          (enabled),
		.room             (room),
		.issue            (issue),
		.response_valid   (response_valid),
		.response_credits (response_credits),
		.credit_available (credit_available)
	);

	tag_table tags (
		.clock        (clock),
		.rst_n        (rst_n),
		.issue        (issue),
		.issue_source (issue_source),
		.issue_tag    (free_tag),
		.lookup_valid (lookup_valid),
		.lookup_tag   (lookup_tag),
		.tag_ready    (tag_ready),
		.free_tag     (free_tag),
		.owner_source (owner_source),
		.owner_hit    (owner_hit)
	);

	//////////////////////////////
	// Response path
	//////////////////////////////

	response_router router (
		.clock          (clock),
		.rst_n          (rst_n),
		.response_valid (response_valid),
		.response_tag   (response_tag),
		.response_code  (response_code),
		.lookup_valid   (lookup_valid),
		.lookup_tag     (lookup_tag),
		.owner_source   (owner_source),
		.owner_hit      (owner_hit),
		.source_valid   (routed_valid),
		.source_tag     (routed_tag),
		.source_code    (routed_code),
		.source_error   (routed_error),
		.tag_error      (tag_error)
	);

	// Fan out to named source ports
	assign restart_response_valid = routed_valid[SOURCE_RESTART];
	assign restart_response_tag   = routed_tag[SOURCE_RESTART];
	assign restart_response_code  = routed_code[SOURCE_RESTART];
	assign restart_response_error = routed_error[SOURCE_RESTART];
	assign write_response_valid   = routed_valid[SOURCE_WRITE];
	assign write_response_tag     = routed_tag[SOURCE_WRITE];
	assign write_response_code    = routed_code[SOURCE_WRITE];
	assign write_response_error   = routed_error[SOURCE_WRITE];
	assign read_response_valid    = routed_valid[SOURCE_READ];
	assign read_response_tag      = routed_tag[SOURCE_READ];
	assign read_response_code     = routed_code[SOURCE_READ];
	assign read_response_error    = routed_error[SOURCE_READ];

endmodule

// File: design/command_queue.sv
`timescale 1ns/1ps

module command_queue #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full
);

	// Pointer is at least one bit wide
	localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]       entries [DEPTH];
	logic [PTR_WIDTH-1:0]   write_ptr;
	logic [PTR_WIDTH-1:0]   read_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	// Push into a full queue or pop from an empty one is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == COUNT_WIDTH'(DEPTH));
	assign data_out = entries[read_ptr];

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
		end else begin
			if (do_push) begin
				// Wrap explicitly, depth need not be a power of two
				if (write_ptr == PTR_WIDTH'(DEPTH - 1))
					write_ptr <= '0;
				else
					write_ptr <= write_ptr + 1'b1;
			end
			if (do_pop) begin
				if (read_ptr == PTR_WIDTH'(DEPTH - 1))
					read_ptr <= '0;
				else
					read_ptr <= read_ptr + 1'b1;
			end
			// Both at once leaves count unchanged
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push)
			entries[write_ptr] <= data_in;
	end

endmodule

// File: design/response_router.sv
`timescale 1ns/1ps

module response_router import afu_pkg::*; (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         response_valid,
	input  tag_t                         response_tag,
	input  resp_code_t                   response_code,
	output logic                         lookup_valid,
	output tag_t                         lookup_tag,
	input  cmd_source_t                  owner_source,
	input  logic                         owner_hit,
	output logic [NUM_SOURCES-1:0]       source_valid,
	output tag_t [NUM_SOURCES-1:0]       source_tag,
	output resp_code_t [NUM_SOURCES-1:0] source_code,
	output logic [NUM_SOURCES-1:0]       source_error,
	output logic                         tag_error
);

	logic       latched_valid;
	tag_t       latched_tag;
	resp_code_t latched_code;
	logic [NUM_SOURCES-1:0] route;

	//////////////////////////////
	// Latch stage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n)
			latched_valid <= 1'b0;
		else
			latched_valid <= response_valid;
	end

	always_ff @(posedge clock) begin
		latched_tag  <= response_tag;
		latched_code <= response_code;
	end

	// Tag table sees the latched tag
	assign lookup_valid = latched_valid;
	assign lookup_tag   = latched_tag;

	//////////////////////////////
	// Routing stage
	//////////////////////////////

	// One hot, empty when the tag was not in use
	always_comb begin
		for (int s = 0; s < NUM_SOURCES; s++)
			route[s] = latched_valid && owner_hit && (owner_source == cmd_source_t'(s));
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			source_valid <= '0;
			source_error <= '0;
			tag_error    <= 1'b0;
		end else begin
			source_valid <= route;
			// Sticky flags
			for (int s = 0; s < NUM_SOURCES; s++) begin
				if (route[s] && latched_code != RESP_DONE)
					source_error[s] <= 1'b1;
			end
			// Unknown tag, response dropped
			if (latched_valid && !owner_hit)
				tag_error <= 1'b1;
		end
	end

	// Payload kept per source
	always_ff @(posedge clock) begin
		for (int s = 0; s < NUM_SOURCES; s++) begin
			if (route[s]) begin
				source_tag[s]  <= latched_tag;
				source_code[s] <= latched_code;
			end
		end
	end

endmodule

// File: files.f
common/afu_pkg.sv
design/command_queue.sv
command_issue/credit_tracker.sv
command_issue/tag_table.sv
command_issue/command_arbiter.sv
design/response_router.sv
design/afu_command_top.sv
verif/afu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module afu_tb -f files.f -o afu_sim &&
./obj_dir/afu_sim > sim.log 2>&1 || echo "Simulation build or run returned an error"
cat sim.log 2>/dev/null
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

// File: verif/afu_tb.sv
`timescale 1ns/1ps

module afu_tb import afu_pkg::*; ();

	// Cycles to wait for one command before giving up
	localparam int COMMAND_TIMEOUT = 50;
	// Window in which no command may appear
	localparam int QUIET_CYCLES = 20;
	// Longest test with its releases stays well under this
	localparam int TEST_BUDGET = 300;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_CYCLES = 10 + NUM_TESTS * TEST_BUDGET;

	logic       clock;
	logic       rst_n;
	logic       enabled;
	credit_t    room;
	logic       restart_push;
	cmd_code_t  restart_code;
	address_t   restart_address;
	logic       restart_full;
	logic       write_push;
	cmd_code_t  write_code;
	address_t   write_address;
	logic       write_full;
	logic       read_push;
	cmd_code_t  read_code;
	address_t   read_address;
	logic       read_full;
	logic       command_valid;
	cmd_code_t  command_code;
	address_t   command_address;
	tag_t       command_tag;
	logic       response_valid;
	tag_t       response_tag;
	resp_code_t response_code;
	credit_t    response_credits;
	logic       restart_response_valid;
	tag_t       restart_response_tag;
	resp_code_t restart_response_code;
	logic       restart_response_error;
	logic       write_response_valid;
	tag_t       write_response_tag;
	resp_code_t write_response_code;
	logic       write_response_error;
	logic       read_response_valid;
	tag_t       read_response_tag;
	resp_code_t read_response_code;
	logic       read_response_error;
	logic       tag_error;

	integer seed = 32;
	// Tags the host still owes a response for
	tag_t   out_tag [$];

	afu_command_top dut (.*);

	// 8 ns clock
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////
	// Failure reporting
	//////////////////////////////

	task automatic fail_run();
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		fail_run();
	endtask

	task automatic compare_code(input string name, input cmd_code_t actual,
		input cmd_code_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			fail_run();
		end
	endtask

	task automatic compare_address(input string name, input address_t actual,
		input address_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			fail_run();
		end
	endtask

	task automatic compare_tag(input string name, input tag_t actual, input tag_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			fail_run();
		end
	endtask

	task automatic compare_resp_code(input string name, input resp_code_t actual,
		input resp_code_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			fail_run();
		end
	endtask

	task automatic compare_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			fail_run();
		end
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// All of these start and end on a falling edge

	task automatic new_command(output cmd_code_t code, output address_t address);
		code    = cmd_code_t'($random(seed));
		address = {$random(seed), $random(seed)};
	endtask

	task automatic set_push(input cmd_source_t source, input cmd_code_t code,
		input address_t address);
		case (source)
			SOURCE_RESTART: begin
				restart_push    = 1'b1;
				restart_code    = code;
				restart_address = address;
			end
			SOURCE_WRITE: begin
				write_push    = 1'b1;
				write_code    = code;
				write_address = address;
			end
			default: begin
				read_push    = 1'b1;
				read_code    = code;
				read_address = address;
			end
		endcase
	endtask

	task automatic clear_pushes();
		restart_push = 1'b0;
		write_push   = 1'b0;
		read_push    = 1'b0;
	endtask

	task automatic push_command(input cmd_source_t source, input cmd_code_t code,
		input address_t address);
		set_push(source, code, address);
		@(negedge clock);
		clear_pushes();
	endtask

	// Link down, nothing issues
	task automatic disable_link();
		enabled = 1'b0;
		@(negedge clock);
	endtask

	// Rising enabled loads room as the credit count
	task automatic enable_link(input credit_t credits);
		room    = credits;
		enabled = 1'b1;
		@(negedge clock);
	endtask

	task automatic send_response(input tag_t tag, input resp_code_t code,
		input credit_t credits);
		response_valid   = 1'b1;
		response_tag     = tag;
		response_code    = code;
		response_credits = credits;
		@(negedge clock);
		response_valid   = 1'b0;
		response_credits = '0;
	endtask

	function automatic void forget_tag(input tag_t tag);
		for (int i = 0; i < out_tag.size(); i++) begin
			if (out_tag[i] == tag) begin
				out_tag.delete(i);
				break;
			end
		end
	endfunction

	// Answer every outstanding tag, one per cycle, no credits back
	task automatic release_tags();
		while (out_tag.size() > 0) begin
			response_valid   = 1'b1;
			response_tag     = out_tag.pop_front();
			response_code    = RESP_DONE;
			response_credits = '0;
			@(negedge clock);
		end
		response_valid = 1'b0;
		// Let the router pipeline drain
		repeat (3) @(negedge clock);
	endtask

	//////////////////////////////
	// Command port checks
	//////////////////////////////

	task automatic wait_command(input cmd_code_t code, input address_t address,
		output tag_t tag);
		int waited;
		waited = 0;
		@(negedge clock);
		while (command_valid !== 1'b1) begin
			waited++;
			if (waited >= COMMAND_TIMEOUT)
				report_failure("No command issued before the command timeout");
			@(negedge clock);
		end
		compare_code("command_code", command_code, code);
		compare_address("command_address", command_address, address);
		tag = command_tag;
		out_tag.push_back(tag);
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (command_valid !== 1'b0)
				report_failure("Command issued while it should have been held back");
		end
	endtask

	task automatic check_distinct_tags();
		for (int i = 0; i < out_tag.size(); i++) begin
			for (int j = i + 1; j < out_tag.size(); j++) begin
				if (out_tag[i] == out_tag[j])
					report_failure($sformatf("Tag 0x%0h is in flight twice", out_tag[i]));
			end
		end
	endtask

	task automatic check_no_response_valid();
		compare_flag("restart_response_valid", restart_response_valid, 1'b0);
		compare_flag("write_response_valid", write_response_valid, 1'b0);
		compare_flag("read_response_valid", read_response_valid, 1'b0);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	// Three pushes on one edge come out restart, write, read
	task automatic test_priority_order();
		cmd_code_t code [NUM_SOURCES];
		address_t  address [NUM_SOURCES];
		tag_t      tag;
		for (int s = 0; s < NUM_SOURCES; s++)
			new_command(code[s], address[s]);
		enable_link(8'd40);
		set_push(SOURCE_READ, code[SOURCE_READ], address[SOURCE_READ]);
		set_push(SOURCE_WRITE, code[SOURCE_WRITE], address[SOURCE_WRITE]);
		set_push(SOURCE_RESTART, code[SOURCE_RESTART], address[SOURCE_RESTART]);
		@(negedge clock);
		clear_pushes();
		wait_command(code[SOURCE_RESTART], address[SOURCE_RESTART], tag);
		wait_command(code[SOURCE_WRITE], address[SOURCE_WRITE], tag);
		wait_command(code[SOURCE_READ], address[SOURCE_READ], tag);
		check_distinct_tags();
	endtask

	// Two credits let two of four reads through
	task automatic test_credit_gating();
		cmd_code_t code [4];
		address_t  address [4];
		tag_t      first_tag;
		tag_t      tag;
		release_tags();
		disable_link();
		for (int i = 0; i < 4; i++) begin
			new_command(code[i], address[i]);
			push_command(SOURCE_READ, code[i], address[i]);
		end
		enable_link(8'd2);
		wait_command(code[0], address[0], first_tag);
		wait_command(code[1], address[1], tag);
		expect_quiet(QUIET_CYCLES);
		// Two credits come back with the response
		send_response(first_tag, RESP_DONE, 8'd2);
		forget_tag(first_tag);
		wait_command(code[2], address[2], tag);
		wait_command(code[3], address[3], tag);
		// Read response lands on the read outputs
		send_response(tag, RESP_DONE, '0);
		forget_tag(tag);
		@(negedge clock);
		compare_flag("read_response_valid", read_response_valid, 1'b1);
		compare_tag("read_response_tag", read_response_tag, tag);
		compare_resp_code("read_response_code", read_response_code, RESP_DONE);
	endtask

	// All tags in flight, freed tags are reused in response order
	task automatic test_tag_exhaustion();
		cmd_code_t code [TAG_COUNT + 2];
		address_t  address [TAG_COUNT + 2];
		tag_t      tags [TAG_COUNT];
		tag_t      tag;
		release_tags();
		disable_link();
		for (int i = 0; i < TAG_COUNT + 2; i++)
			new_command(code[i], address[i]);
		for (int i = 0; i < TAG_COUNT; i++)
			push_command(SOURCE_READ, code[i], address[i]);
		// Read queue holds exactly as many as the tag table
		compare_flag("read_full", read_full, 1'b1);
		compare_flag("write_full", write_full, 1'b0);
		compare_flag("restart_full", restart_full, 1'b0);
		enable_link(8'd40);
		for (int i = 0; i < TAG_COUNT; i++)
			wait_command(code[i], address[i], tags[i]);
		compare_flag("read_full", read_full, 1'b0);
		check_distinct_tags();
		push_command(SOURCE_READ, code[TAG_COUNT], address[TAG_COUNT]);
		push_command(SOURCE_READ, code[TAG_COUNT + 1], address[TAG_COUNT + 1]);
		expect_quiet(QUIET_CYCLES);
		send_response(tags[4], RESP_DONE, '0);
		send_response(tags[10], RESP_DONE, '0);
		forget_tag(tags[4]);
		forget_tag(tags[10]);
		wait_command(code[TAG_COUNT], address[TAG_COUNT], tag);
		compare_tag("command_tag", tag, tags[4]);
		wait_command(code[TAG_COUNT + 1], address[TAG_COUNT + 1], tag);
		compare_tag("command_tag", tag, tags[10]);
	endtask

	// Write response shows up on the write outputs two cycles later
	task automatic test_response_routing();
		cmd_code_t code;
		address_t  address;
		tag_t      tag;
		release_tags();
		new_command(code, address);
		push_command(SOURCE_WRITE, code, address);
		wait_command(code, address, tag);
		send_response(tag, RESP_DONE, '0);
		forget_tag(tag);
		check_no_response_valid();
		@(negedge clock);
		compare_flag("write_response_valid", write_response_valid, 1'b1);
		compare_flag("restart_response_valid", restart_response_valid, 1'b0);
		compare_flag("read_response_valid", read_response_valid, 1'b0);
		compare_tag("write_response_tag", write_response_tag, tag);
		compare_resp_code("write_response_code", write_response_code, RESP_DONE);
		// Single cycle pulse
		@(negedge clock);
		check_no_response_valid();
	endtask

	// Sticky source error, then a response to a tag nobody owns
	task automatic test_error_flags();
		cmd_code_t code;
		address_t  address;
		tag_t      tag;
		cmd_code_t fill_code [RESTART_QUEUE_DEPTH];
		address_t  fill_address [RESTART_QUEUE_DEPTH];
		release_tags();
		new_command(code, address);
		push_command(SOURCE_RESTART, code, address);
		wait_command(code, address, tag);
		send_response(tag, 8'h5a, '0);
		forget_tag(tag);
		@(negedge clock);
		compare_flag("restart_response_valid", restart_response_valid, 1'b1);
		compare_tag("restart_response_tag", restart_response_tag, tag);
		compare_resp_code("restart_response_code", restart_response_code, 8'h5a);
		compare_flag("restart_response_error", restart_response_error, 1'b1);
		repeat (5) @(negedge clock);
		compare_flag("restart_response_error", restart_response_error, 1'b1);
		compare_flag("write_response_error", write_response_error, 1'b0);
		compare_flag("read_response_error", read_response_error, 1'b0);
		compare_flag("tag_error", tag_error, 1'b0);
		// Table is empty, tag 9 is free
		send_response(8'd9, RESP_DONE, '0);
		check_no_response_valid();
		@(negedge clock);
		check_no_response_valid();
		compare_flag("tag_error", tag_error, 1'b1);
		@(negedge clock);
		check_no_response_valid();
		compare_flag("tag_error", tag_error, 1'b1);
		compare_flag("restart_response_error", restart_response_error, 1'b1);
		// Restart queue fills while the link is down
		disable_link();
		for (int i = 0; i < RESTART_QUEUE_DEPTH; i++) begin
			new_command(fill_code[i], fill_address[i]);
			push_command(SOURCE_RESTART, fill_code[i], fill_address[i]);
		end
		compare_flag("restart_full", restart_full, 1'b1);
		enable_link(8'd4);
		for (int i = 0; i < RESTART_QUEUE_DEPTH; i++)
			wait_command(fill_code[i], fill_address[i], tag);
		compare_flag("restart_full", restart_full, 1'b0);
	endtask

	//////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////

	initial begin
		rst_n            = 1'b0;
		enabled          = 1'b0;
		room             = '0;
		clear_pushes();
		restart_code     = '0;
		restart_address  = '0;
		write_code       = '0;
		write_address    = '0;
		read_code        = '0;
		read_address     = '0;
		response_valid   = 1'b0;
		response_tag     = '0;
		response_code    = RESP_DONE;
		response_credits = '0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		test_priority_order();
		test_credit_gating();
		test_tag_exhaustion();
		test_response_routing();
		test_error_flags();
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		report_failure("Watchdog expired before the tests finished");
	end

endmodule
